//--- exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  lc3_isa_pkg::lc3_instr_u instr,
    input  lc3_isa_pkg::word_t      instr_pc,
    output logic                    instr_taken,
    output logic                    redirect,
    output lc3_isa_pkg::word_t      redirect_pc,
    output logic                    data_req,
    output logic                    data_we,
    output lc3_isa_pkg::word_t      data_addr,
    output lc3_isa_pkg::word_t      data_wdata,
    input  logic                    data_ack,
    input  lc3_isa_pkg::word_t      data_rdata
);
    import lc3_isa_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_EXEC = 2'd1;
    localparam logic [1:0] S_MEM  = 2'd2;

    logic [1:0] state;
    lc3_instr_u ir;
    word_t      ir_pc;
    logic       flag_n;
    logic       flag_z;
    logic       flag_p;
    word_t      rd_a;
    word_t      rd_b;
    reg_idx_t   rd_b_idx;
    word_t      sext5;
    word_t      sext6;
    word_t      sext9;
    word_t      sext11;
    word_t      op_b;
    word_t      wb_val;
    word_t      target;
    logic       wb_reg;
    logic       jump;
    logic       is_load;
    logic       is_store;
    logic       wr_en;
    logic       set_cc;
    logic       br_hit;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////
    // sign extension of every immediate and offset
    assign sext5  = {{11{ir.op.imm5[4]}}, ir.op.imm5};
    assign sext6  = {{10{ir.op.imm_sw}}, ir.op.imm_sw, ir.op.imm5};
    assign sext9  = {{7{ir.pcrel.offset9[8]}}, ir.pcrel.offset9};
    assign sext11 = {{5{ir.jump.offset11[10]}}, ir.jump.offset11};

    assign is_load  = (ir.op.opcode == OP_LD) || (ir.op.opcode == OP_LDR);
    assign is_store = (ir.op.opcode == OP_ST) || (ir.op.opcode == OP_STR);

    // port b is sr2 for operates, the source register for stores
    assign rd_b_idx = is_store ? ir.op.dr : ir.op.imm5[2:0];
    assign op_b     = ir.op.imm_sw ? sext5 : rd_b;
    assign br_hit   = |(ir.pcrel.dr_nzp & {flag_n, flag_z, flag_p});

    always_comb begin
        wb_val = '0;
        wb_reg = 1'b0;
        jump   = 1'b0;
        target = ir_pc + sext9;
        case (ir.op.opcode)
            OP_ADD: begin
                wb_val = rd_a + op_b;
                wb_reg = 1'b1;
            end
            OP_AND: begin
                wb_val = rd_a & op_b;
                wb_reg = 1'b1;
            end
            OP_NOT: begin
                wb_val = ~rd_a;
                wb_reg = 1'b1;
            end
            OP_LEA: begin
                wb_val = ir_pc + sext9;
                wb_reg = 1'b1;
            end
            OP_BR: begin
                jump = br_hit;
            end
            OP_JMP: begin
                jump   = 1'b1;
                target = rd_a;
            end
            OP_JSR: begin
                // link is the incremented pc
                wb_val = ir_pc;
                wb_reg = 1'b1;
                jump   = 1'b1;
                target = ir.jump.jsr_sw ? ir_pc + sext11 : rd_a;
            end
            OP_LD, OP_LDR: begin
                // written back only once the ack comes
                wb_val = data_rdata;
            end
            default: begin
            end
        endcase
    end

    assign wr_en  = ((state == S_EXEC) && wb_reg) ||
                    ((state == S_MEM) && data_ack && is_load);
    // jsr writes r7 but leaves the flags alone
    assign set_cc = wr_en && (ir.op.opcode != OP_JSR);

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_a_idx (ir.op.sr1),
        .rd_b_idx (rd_b_idx),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .we       (wr_en),
        .wr_idx   ((ir.op.opcode == OP_JSR) ? LINK_REG : ir.op.dr),
        .wr_data  (wb_val)
    );

    //////////////////////////////////////////////////
    // sequencing and flags
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            flag_n <= 1'b0;
            flag_z <= 1'b1;
            flag_p <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (instr_valid) state <= S_EXEC;
                S_EXEC: state <= (is_load || is_store) ? S_MEM : S_IDLE;
                S_MEM:  if (data_ack) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            if (set_cc) begin
                flag_n <= wb_val[15];
                flag_z <= (wb_val == 16'h0000);
                flag_p <= !wb_val[15] && (wb_val != 16'h0000);
            end
        end
    end

    // instruction and its incremented pc held for the whole run
    always_ff @(posedge clk) begin
        if (instr_taken) begin
            ir    <= instr;
            ir_pc <= instr_pc;
        end
    end

    assign instr_taken = (state == S_IDLE) && instr_valid;
    assign redirect    = (state == S_EXEC) && jump;
    assign redirect_pc = target;

    // address and data stay put while the request waits
    assign data_req   = (state == S_MEM);
    assign data_we    = is_store;
    assign data_addr  = ((ir.op.opcode == OP_LD) || (ir.op.opcode == OP_ST)) ?
                        ir_pc + sext9 : rd_a + sext6;
    assign data_wdata = rd_b;

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter lc3_isa_pkg::word_t RESET_PC = 16'h3000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    fetch_req,
    output lc3_isa_pkg::word_t      fetch_addr,
    input  logic                    fetch_ack,
    input  lc3_isa_pkg::word_t      fetch_rdata,
    output logic                    instr_valid,
    output lc3_isa_pkg::lc3_instr_u instr,
    output lc3_isa_pkg::word_t      instr_pc,
    input  logic                    instr_taken,
    input  logic                    redirect,
    input  lc3_isa_pkg::word_t      redirect_pc
);
    import lc3_isa_pkg::*;

    word_t      pc;
    word_t      addr_q;
    logic       req;
    logic       discard;
    logic       buf_valid;
    lc3_instr_u buf_instr;
    word_t      buf_pc;
    logic       issue;
    logic       keep;

    // new read only once the buffer is free at ack time
    assign issue = !req && !redirect && (!buf_valid || instr_taken);
    // ack data is kept unless a redirect made it stale
    assign keep  = fetch_ack && !discard && !redirect;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= RESET_PC;
            req       <= 1'b0;
            discard   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (issue) begin
                pc <= pc + 16'd1;
            end
            // request held until its ack
            if (issue) begin
                req <= 1'b1;
            end else if (fetch_ack) begin
                req <= 1'b0;
            end
            // read already on the bus when the redirect came
            if (fetch_ack) begin
                discard <= 1'b0;
            end else if (redirect && req) begin
                discard <= 1'b1;
            end
            if (redirect) begin
                buf_valid <= 1'b0;
            end else if (keep) begin
                buf_valid <= 1'b1;
            end else if (instr_taken) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // address and buffer payload
    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= pc;
        end
        if (keep) begin
            buf_instr <= fetch_rdata;
            buf_pc    <= addr_q + 16'd1;
        end
    end

    assign fetch_req   = req;
    assign fetch_addr  = addr_q;
    assign instr_valid = buf_valid;
    assign instr       = buf_instr;
    assign instr_pc    = buf_pc;

endmodule

//--- lc3_bus_pkg.sv
package lc3_bus_pkg;

    // axi4-lite response codes seen on bresp and rresp
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // who holds the memory port right now
    typedef enum logic {
        FETCH = 1'b0,
        EXEC  = 1'b1
    } requester_e;

endpackage

//--- lc3_isa_pkg.sv
package lc3_isa_pkg;

    // data and address word, word addressed memory
    typedef logic [15:0] word_t;

    // general register index
    typedef logic [2:0] reg_idx_t;

    localparam int NUM_REGS = 8;

    // jsr and jsrr leave the return address here
    localparam reg_idx_t LINK_REG = 3'd7;

    // kept subset, anything else decodes as a nop
    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_LD  = 4'b0010,
        OP_ST  = 4'b0011,
        OP_JSR = 4'b0100,
        OP_AND = 4'b0101,
        OP_LDR = 4'b0110,
        OP_STR = 4'b0111,
        OP_NOT = 4'b1001,
        OP_JMP = 4'b1100,
        OP_LEA = 4'b1110
    } opcode_e;

    // one instruction word, three ways of slicing it
    typedef union packed {
        // operate view, also base_r (sr1) and offset6 ({imm_sw, imm5})
        struct packed {
            opcode_e    opcode;
            reg_idx_t   dr;
            reg_idx_t   sr1;
            logic       imm_sw;
            logic [4:0] imm5;
        } op;
        // pc relative view, dr or n/z/p on top of a 9-bit offset
        struct packed {
            opcode_e    opcode;
            logic [2:0] dr_nzp;
            logic [8:0] offset9;
        } pcrel;
        // jump view, jsr_sw set for jsr and clear for jsrr
        struct packed {
            opcode_e     opcode;
            logic        jsr_sw;
            logic [10:0] offset11;
        } jump;
    } lc3_instr_u;

endpackage

//--- lc3_top.sv
`timescale 1ns/1ns

module lc3_top #(
    parameter lc3_isa_pkg::word_t RESET_PC = 16'h3000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic                   awvalid,
    input  logic                   awready,
    output lc3_isa_pkg::word_t     awaddr,
    output logic                   wvalid,
    input  logic                   wready,
    output lc3_isa_pkg::word_t     wdata,
    input  logic                   bvalid,
    output logic                   bready,
    input  lc3_bus_pkg::axi_resp_e bresp,
    output logic                   arvalid,
    input  logic                   arready,
    output lc3_isa_pkg::word_t     araddr,
    input  logic                   rvalid,
    output logic                   rready,
    input  lc3_isa_pkg::word_t     rdata,
    input  lc3_bus_pkg::axi_resp_e rresp
);
    import lc3_isa_pkg::*;

    // fetch port
    logic       fetch_req;
    logic       fetch_ack;
    word_t      fetch_addr;
    word_t      fetch_rdata;
    // dispatch port
    logic       instr_valid;
    logic       instr_taken;
    lc3_instr_u instr;
    word_t      instr_pc;
    logic       redirect;
    word_t      redirect_pc;
    // data port
    logic       data_req;
    logic       data_we;
    logic       data_ack;
    word_t      data_addr;
    word_t      data_wdata;
    word_t      data_rdata;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (.*);

    exec_unit u_exec (.*);

    mem_arbiter u_arb (.*);

endmodule

//--- list.f
lc3_isa_pkg.sv
lc3_bus_pkg.sv
reg_file.sv
fetch_unit.sv
exec_unit.sv
mem_arbiter.sv
lc3_top.sv
tb_axil_mem.sv
tb_lc3.sv

//--- mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_req,
    input  lc3_isa_pkg::word_t    fetch_addr,
    output logic                  fetch_ack,
    output lc3_isa_pkg::word_t    fetch_rdata,
    input  logic                  data_req,
    input  logic                  data_we,
    input  lc3_isa_pkg::word_t    data_addr,
    input  lc3_isa_pkg::word_t    data_wdata,
    output logic                  data_ack,
    output lc3_isa_pkg::word_t    data_rdata,
    output logic                  awvalid,
    input  logic                  awready,
    output lc3_isa_pkg::word_t    awaddr,
    output logic                  wvalid,
    input  logic                  wready,
    output lc3_isa_pkg::word_t    wdata,
    input  logic                  bvalid,
    output logic                  bready,
    input  lc3_bus_pkg::axi_resp_e bresp,
    output logic                  arvalid,
    input  logic                  arready,
    output lc3_isa_pkg::word_t    araddr,
    input  logic                  rvalid,
    output logic                  rready,
    input  logic [15:0]           rdata,
    input  lc3_bus_pkg::axi_resp_e rresp
);
    import lc3_isa_pkg::*;
    import lc3_bus_pkg::*;

    localparam logic [2:0] A_IDLE = 3'd0;
    localparam logic [2:0] A_AR   = 3'd1;
    localparam logic [2:0] A_R    = 3'd2;
    localparam logic [2:0] A_AW_W = 3'd3;
    localparam logic [2:0] A_B    = 3'd4;

    logic [2:0] state;
    requester_e owner;
    word_t      addr_q;
    word_t      wdata_q;
    logic       aw_done;
    logic       w_done;
    logic       aw_ok;
    logic       w_ok;

    // either side of the write is done now or was done before
    assign aw_ok = aw_done || awready;
    assign w_ok  = w_done || wready;

    //////////////////////////////////////////////////
    // grant and channel sequence
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= A_IDLE;
            owner   <= FETCH;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                A_IDLE: begin
                    // data side first
                    if (data_req) begin
                        owner <= EXEC;
                        state <= data_we ? A_AW_W : A_AR;
                    end else if (fetch_req) begin
                        owner <= FETCH;
                        state <= A_AR;
                    end
                end
                A_AR: if (arready) state <= A_R;
                A_R:  if (rvalid) state <= A_IDLE;
                A_AW_W: begin
                    if (aw_ok && w_ok) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= A_B;
                    end else begin
                        aw_done <= aw_ok;
                        w_done  <= w_ok;
                    end
                end
                // slverr completes just like okay
                A_B: if (bvalid) state <= A_IDLE;
                default: state <= A_IDLE;
            endcase
        end
    end

    // payload captured with the grant
    always_ff @(posedge clk) begin
        if (state == A_IDLE) begin
            addr_q  <= data_req ? data_addr : fetch_addr;
            wdata_q <= data_wdata;
        end
    end

    assign arvalid = (state == A_AR);
    assign araddr  = addr_q;
    assign rready  = (state == A_R);
    assign awvalid = (state == A_AW_W) && !aw_done;
    assign awaddr  = addr_q;
    assign wvalid  = (state == A_AW_W) && !w_done;
    assign wdata   = wdata_q;
    assign bready  = (state == A_B);

    // ack pulses in the response handshake cycle
    assign fetch_ack   = (state == A_R) && rvalid && (owner == FETCH);
    assign data_ack    = ((state == A_R) && rvalid && (owner == EXEC)) ||
                         ((state == A_B) && bvalid);
    assign fetch_rdata = rdata;
    assign data_rdata  = rdata;

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lc3_isa_pkg::reg_idx_t rd_a_idx,
    input  lc3_isa_pkg::reg_idx_t rd_b_idx,
    output lc3_isa_pkg::word_t    rd_a,
    output lc3_isa_pkg::word_t    rd_b,
    input  logic                  we,
    input  lc3_isa_pkg::reg_idx_t wr_idx,
    input  lc3_isa_pkg::word_t    wr_data
);
    import lc3_isa_pkg::*;

    word_t regs [NUM_REGS];

    // single write port, lands at the clock edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // combinational reads, old value during a write cycle
    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];

endmodule

//--- tb_axil_mem.sv
`timescale 1ns/1ns

module tb_axil_mem (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [15:0]            awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [15:0]            wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output lc3_bus_pkg::axi_resp_e bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [15:0]            araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [15:0]            rdata,
    output lc3_bus_pkg::axi_resp_e rresp
);
    import lc3_bus_pkg::*;

    logic [15:0] mem [65536];
    logic [15:0] lfsr;
    logic [15:0] rd_addr;
    logic [15:0] wr_addr;
    logic [15:0] wr_data;
    logic        rd_pend;
    logic        b_pend;
    logic        aw_got;
    logic        w_got;
    // reset as seen at the last rising edge
    logic        running;
    logic [1:0]  ar_cnt;
    logic [1:0]  aw_cnt;
    logic [1:0]  w_cnt;
    logic [1:0]  r_cnt;
    logic [1:0]  b_cnt;

    // galois lfsr, one step per bit taken
    function automatic logic next_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return lsb;
    endfunction

    // stall of 0 to 3 cycles
    function automatic logic [1:0] delay();
        logic [1:0] d;
        d[0] = next_bit();
        d[1] = next_bit();
        return d;
    endfunction

    // fill pattern, every address bit matters
    initial begin
        lfsr = 16'd5430;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = {i[7:0], i[15:8]} ^ 16'hC3A5;
        end
        {awready, wready, bvalid, arready, rvalid, rdata} = '0;
        {ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt} = '0;
        {rd_pend, b_pend, aw_got, w_got} = '0;
        running = 1'b0;
        bresp = OKAY;
        rresp = OKAY;
    end

    //////////////////////////////////////////////////
    // handshake capture at the rising edge
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        running <= rst_n;
        if (arvalid && arready) begin
            rd_addr <= araddr;
            rd_pend <= 1'b1;
        end
        if (rvalid && rready) begin
            rd_pend <= 1'b0;
        end
        if (awvalid && awready) begin
            wr_addr <= awaddr;
            aw_got  <= 1'b1;
        end
        if (wvalid && wready) begin
            wr_data <= wdata;
            w_got   <= 1'b1;
        end
        // both halves in, commit and owe a response
        if (aw_got && w_got) begin
            mem[wr_addr] <= wr_data;
            aw_got       <= 1'b0;
            w_got        <= 1'b0;
            b_pend       <= 1'b1;
        end
        if (bvalid && bready) begin
            b_pend <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // readies and responses change on the falling edge
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!running) begin
            {awready, wready, bvalid, arready, rvalid} <= '0;
        end else begin
            if (arvalid && !arready) begin
                if (ar_cnt == 0) arready <= 1'b1;
                else ar_cnt <= ar_cnt - 1;
            end else if (!arvalid) begin
                arready <= 1'b0;
                ar_cnt  <= delay();
            end
            if (awvalid && !awready) begin
                if (aw_cnt == 0) awready <= 1'b1;
                else aw_cnt <= aw_cnt - 1;
            end else if (!awvalid) begin
                awready <= 1'b0;
                aw_cnt  <= delay();
            end
            if (wvalid && !wready) begin
                if (w_cnt == 0) wready <= 1'b1;
                else w_cnt <= w_cnt - 1;
            end else if (!wvalid) begin
                wready <= 1'b0;
                w_cnt  <= delay();
            end
            if (rd_pend && !rvalid) begin
                if (r_cnt == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[rd_addr];
                end else begin
                    r_cnt <= r_cnt - 1;
                end
            end else if (!rd_pend) begin
                rvalid <= 1'b0;
                r_cnt  <= delay();
            end
            if (b_pend && !bvalid) begin
                if (b_cnt == 0) bvalid <= 1'b1;
                else b_cnt <= b_cnt - 1;
            end else if (!b_pend) begin
                bvalid <= 1'b0;
                b_cnt  <= delay();
            end
        end
    end

endmodule

//--- tb_lc3.sv
`timescale 1ns/1ns

module tb_lc3;
    import lc3_isa_pkg::*;
    import lc3_bus_pkg::*;

    localparam word_t START = 16'h3000;

    logic      clk;
    logic      rst_n;
    logic      awvalid;
    logic      awready;
    word_t     awaddr;
    logic      wvalid;
    logic      wready;
    word_t     wdata;
    logic      bvalid;
    logic      bready;
    axi_resp_e bresp;
    logic      arvalid;
    logic      arready;
    word_t     araddr;
    logic      rvalid;
    logic      rready;
    word_t     rdata;
    axi_resp_e rresp;

    word_t     model_mem [65536];
    logic      wrote [65536];
    logic [15:0] lfsr;
    int        at;
    int        slot;
    int        mark;
    word_t     halt_addr;
    int        halt_reads;
    int        outstanding;
    int        after_rst;
    logic      seen_first;
    logic      ar_wait;
    logic      aw_wait;
    logic      w_wait;
    word_t     ar_hold;
    word_t     aw_hold;
    word_t     w_hold;

    lc3_top #(.RESET_PC(START)) UUT (.*);

    tb_axil_mem u_mem (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic logic next_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        for (int i = 0; i < 16; i++) begin
            w[i] = next_bit();
        end
        return w;
    endfunction

    //////////////////////////////////////////////////
    // program building
    //////////////////////////////////////////////////
    task automatic put(input word_t w);
        model_mem[START + at] = w;
        at++;
    endtask

    // offsets relative to the incremented pc of the word at "at"
    function automatic logic [8:0] off9(input int target);
        int d;
        d = target - (at + 1);
        return d[8:0];
    endfunction

    function automatic logic [10:0] off11(input int target);
        int d;
        d = target - (at + 1);
        return d[10:0];
    endfunction

    // str r, r6, #-slot into the result area below word 63
    task automatic save(input logic [2:0] r);
        logic [5:0] o;
        slot++;
        o = 6'(0 - slot);
        put({OP_STR, r, 3'd6, o});
    endtask

    task automatic build_program();
        logic [8:0] imm;
        at = 0;
        put({OP_BR, 3'b111, 9'd67});
        // literal pool of lfsr operands
        for (int i = 0; i < 8; i++) begin
            put(rand_word());
        end
        // subroutines just store the link and return
        at = 64;
        save(3'd7);
        put({OP_JMP, 3'b000, 3'd7, 6'd0});
        save(3'd7);
        put({OP_JMP, 3'b000, 3'd7, 6'd0});
        // main starts at word 68
        put({OP_LEA, 3'd6, off9(63)});
        put({OP_LD, 3'd1, off9(1)});
        put({OP_LD, 3'd2, off9(2)});
        put({OP_LD, 3'd3, off9(3)});
        // arithmetic, register and immediate forms
        put({OP_ADD, 3'd4, 3'd1, 3'b000, 3'd2});
        save(3'd4);
        put({OP_ADD, 3'd4, 3'd1, 1'b1, 5'b11001});
        save(3'd4);
        put({OP_ADD, 3'd4, 3'd2, 1'b1, 5'b01101});
        save(3'd4);
        put({OP_AND, 3'd4, 3'd1, 3'b000, 3'd2});
        save(3'd4);
        put({OP_AND, 3'd4, 3'd1, 1'b1, 5'b11101});
        save(3'd4);
        put({OP_NOT, 3'd4, 3'd2, 6'h3F});
        save(3'd4);
        // every nzp mask after a negative, zero and positive result
        mark = 9;
        for (int f = 0; f < 3; f++) begin
            imm = (f == 0) ? 9'h1F : (f == 1) ? 9'h00 : 9'h01;
            if (f == 1) put({OP_AND, 3'd5, 3'd0, 1'b1, imm[4:0]});
            else put({OP_ADD, 3'd5, 3'd0, 1'b1, imm[4:0]});
            for (int c = 1; c < 8; c++) begin
                put({OP_BR, 3'(c), 9'd1});
                // marker lands only when the branch falls through
                put({OP_ST, 3'd3, off9(mark)});
                mark++;
            end
        end
        // jsr, then jsrr through r2
        put({OP_JSR, 1'b1, off11(64)});
        save(3'd3);
        put({OP_LEA, 3'd2, off9(66)});
        put({OP_JSR, 1'b0, 2'b00, 3'd2, 6'd0});
        save(3'd3);
        // base plus negative offset, lea and ld
        put({OP_LDR, 3'd4, 3'd6, 6'h3F});
        put({OP_ADD, 3'd4, 3'd4, 1'b1, 5'b00001});
        save(3'd4);
        put({OP_LEA, 3'd4, off9(at)});
        save(3'd4);
        put({OP_LD, 3'd4, off9(4)});
        save(3'd4);
        halt_addr = START + at;
        put(16'h0FFF);
    endtask

    //////////////////////////////////////////////////
    // reference model, plain lc-3 semantics
    //////////////////////////////////////////////////
    task automatic run_model();
        word_t r [8];
        word_t pc;
        word_t ir;
        word_t v;
        word_t a;
        word_t b;
        logic  n;
        logic  z;
        logic  p;
        logic  wr;
        for (int i = 0; i < 8; i++) r[i] = '0;
        {n, z, p} = 3'b010;
        pc = START;
        for (int step = 0; step < 4000; step++) begin
            ir = model_mem[pc];
            if (ir == 16'h0FFF) break;
            pc++;
            wr = 1'b1;
            b  = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
            a  = pc + {{7{ir[8]}}, ir[8:0]};
            case (ir[15:12])
                4'd1:  v = r[ir[8:6]] + b;
                4'd5:  v = r[ir[8:6]] & b;
                4'd9:  v = ~r[ir[8:6]];
                4'd14: v = a;
                4'd2:  v = model_mem[a];
                4'd6:  v = model_mem[r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]}];
                default: wr = 1'b0;
            endcase
            if (wr) begin
                r[ir[11:9]] = v;
                n = v[15];
                z = (v == 16'h0000);
                p = !v[15] && (v != 16'h0000);
            end
            if (ir[15:12] == 4'd3 || ir[15:12] == 4'd7) begin
                if (ir[15:12] == 4'd7) a = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
                model_mem[a] = r[ir[11:9]];
                wrote[a] = 1'b1;
            end
            if (ir[15:12] == 4'd0 && (ir[11:9] & {n, z, p}) != 0) pc = a;
            if (ir[15:12] == 4'd12) pc = r[ir[8:6]];
            if (ir[15:12] == 4'd4) begin
                v = pc;
                pc = ir[11] ? pc + {{5{ir[10]}}, ir[10:0]} : r[ir[8:6]];
                r[7] = v;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // bus monitor
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        if (!rst_n || after_rst == 0) begin
            assert (!arvalid && !awvalid && !wvalid)
            else fail_now("a valid was high during or right after reset");
        end
        if (rst_n) begin
            after_rst++;
            assert (!ar_wait || (arvalid && araddr == ar_hold))
            else fail_now("arvalid dropped or araddr changed before arready");
            assert (!aw_wait || (awvalid && awaddr == aw_hold))
            else fail_now("awvalid dropped or awaddr changed before awready");
            assert (!w_wait || (wvalid && wdata == w_hold))
            else fail_now("wvalid dropped or wdata changed before wready");
            // a response on offer must find its ready high
            assert (!rvalid || rready)
            else fail_now("rready low while the read response was waiting");
            assert (!bvalid || bready)
            else fail_now("bready low while the write response was waiting");
            if (rvalid && rready) outstanding--;
            if (bvalid && bready) outstanding--;
            if (arvalid && arready) begin
                if (!seen_first) begin
                    assert (araddr == START)
                    else fail_now($sformatf("[FAIL] first_fetch expected %h actual %h",
                                            START, araddr));
                    seen_first = 1'b1;
                end
                if (araddr == halt_addr) halt_reads++;
                outstanding++;
            end
            if (awvalid && awready) begin
                assert (wrote[awaddr])
                else fail_now($sformatf("write to unexpected address %h", awaddr));
                outstanding++;
            end
            assert (outstanding <= 1)
            else fail_now("more than one bus transaction outstanding");
        end
        ar_wait = rst_n && arvalid && !arready;
        aw_wait = rst_n && awvalid && !awready;
        w_wait  = rst_n && wvalid && !wready;
        ar_hold = araddr;
        aw_hold = awaddr;
        w_hold  = wdata;
    end

    initial begin
        int cyc;
        rst_n       = 1'b0;
        lfsr        = 16'd5430;
        halt_reads  = 0;
        outstanding = 0;
        after_rst   = 0;
        seen_first  = 1'b0;
        {ar_wait, aw_wait, w_wait} = '0;
        slot = 0;
        halt_addr = '1;
        #1;
        for (int i = 0; i < 65536; i++) begin
            model_mem[i] = u_mem.mem[i];
            wrote[i] = 1'b0;
        end
        build_program();
        for (int i = 0; i < at; i++) begin
            u_mem.mem[START + i] = model_mem[START + i];
        end
        run_model();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        // halt loop fetched twice means everything before it retired
        for (cyc = 0; cyc < 20000 && halt_reads < 2; cyc++) begin
            @(negedge clk);
        end
        if (halt_reads < 2) begin
            fail_now("timeout before the halt loop was fetched twice");
        end else begin
            for (int i = 0; i < 65536; i++) begin
                assert (u_mem.mem[i] == model_mem[i])
                else fail_now($sformatf("[FAIL] mem_%h expected %h actual %h",
                                        i[15:0], model_mem[i], u_mem.mem[i]));
            end
            $display("Everything OK");
            $finish;
        end
    end

endmodule
